//--- Makefile
# Verilator build and run of the reorder buffer testbench

.PHONY: all run lint clean

all: run

obj_dir/VtbRob: list.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tbRob -f list.f

run: obj_dir/VtbRob
	./obj_dir/VtbRob | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module robTop -f list.f

clean:
	rm -rf obj_dir sim.log

//--- commitScan.sv
`timescale 1ns/10ps
`include "rob_defines.svh"

module commitScan (
    input  robPkg::RobEntry   window [`ROB_WIDTH-1:0],
    input  robPkg::SqN        head,
    input  logic              stopped,
    output robPkg::CommitPlan plan
);

    always_comb begin
        logic blocked;
        logic trapSeen;
        logic fpExc;
        logic traps;
        robPkg::SqN slotSqN;
        robPkg::RobEntry e;

        plan = '0;
        blocked = stopped;
        trapSeen = 1'b0;

        for (int k = 0; k < `ROB_WIDTH; k++) begin
            e = window[k];
            slotSqN = head + robPkg::SqN'(k);
            fpExc = e.isFP && e.flags.fp.isExc;
            traps = !fpExc && e.flags.code >= robPkg::PRED_TAKEN;

            // Entry must belong to the current lap of the sequence space
            if (!blocked && e.valid && e.wrap == slotSqN[`ROB_SQN_W-1]
                    && e.flags.code != robPkg::NX
                    && (!trapSeen || e.flags.code == robPkg::NONE)) begin
                plan.retire[k] = 1'b1;
                plan.count = plan.count + 1'b1;

                if (traps) begin
                    plan.trapValid = 1'b1;
                    plan.trapSlot = robPkg::SlotIdx'(k);
                    trapSeen = 1'b1;
                    // Serializing ops end the group
                    if (e.flags.code >= robPkg::FENCE) begin
                        blocked = 1'b1;
                    end
                end else if (fpExc && e.flags.fp.idx <= robPkg::FP_NV) begin
                    plan.fpFlags[e.flags.fp.idx] = 1'b1;
                    // Underflow and overflow are inexact as well
                    if (e.flags.fp.idx == robPkg::FP_UF || e.flags.fp.idx == robPkg::FP_OF) begin
                        plan.fpFlags[robPkg::FP_NX] = 1'b1;
                    end
                end
            end else begin
                blocked = 1'b1;
            end
        end
    end

endmodule

//--- list.f
+incdir+.
robPkg.sv
robStorage.sv
commitScan.sv
replayWalker.sv
retireControl.sv
robTop.sv
tbRob.sv

//--- replayWalker.sv
`timescale 1ns/10ps
`include "rob_defines.svh"

module replayWalker (
    input  logic              clk,
    input  logic              rst,
    input  robPkg::BranchIn   branch,
    input  robPkg::SqN        head,
    input  robPkg::RobEntry   window [`ROB_WIDTH-1:0],
    output robPkg::SqN        iter,
    output robPkg::ReplayPlan plan
);

    logic active;
    robPkg::SqN endSqN;
    logic [`ROB_WIDTH-1:0] windowValid;

    // Slots up to and including the branch are replayed, the first one past it ends the walk
    always_comb begin
        robPkg::SqN slotSqN;

        plan = '0;
        plan.active = active;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            slotSqN = iter + robPkg::SqN'(k);
            windowValid[k] = window[k].valid;
            if (robPkg::isYounger(slotSqN, endSqN)) begin
                plan.done = active;
            end else begin
                plan.replay[k] = active;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (branch.taken) begin
            // A newer mispredict restarts the walk from the head
            active <= 1'b1;
            endSqN <= branch.sqN;
            iter <= head;
        end else if (active) begin
            if (plan.done) begin
                active <= 1'b0;
            end else begin
                iter <= iter + robPkg::SqN'(`ROB_WIDTH);
            end
        end
    end

    // Everything between head and branch is still held by storage
    assert property (@(posedge clk) disable iff (rst)
        (plan.active && !branch.taken) |-> ((plan.replay & ~windowValid) == '0));

endmodule

//--- retireControl.sv
`timescale 1ns/10ps
`include "rob_defines.svh"

module retireControl (
    input  logic              clk,
    input  logic              rst,
    input  robPkg::CommitPlan commitPlan,
    input  robPkg::ReplayPlan replayPlan,
    input  robPkg::SqN        replayIter,
    input  robPkg::RobEntry   window [`ROB_WIDTH-1:0],
    input  robPkg::BranchIn   branch,
    output robPkg::RobIdx     readIndex,
    output logic [`ROB_WIDTH-1:0] retireClear,
    output logic              stopped,
    output robPkg::CommitOp   commit [`ROB_WIDTH-1:0],
    output robPkg::TrapOp     trap,
    output logic [4:0]        fpFlags,
    output logic              mispredFlush,
    output robPkg::SqN        curSqN,
    output robPkg::SqN        maxSqN,
    output robPkg::FetchId    curFetchId
);

    robPkg::SqN head;
    logic stop;
    logic commitMode;
    robPkg::RobEntry trapEntry;

    function automatic robPkg::CommitOp makeOp(robPkg::RobEntry e, robPkg::SqN sqN,
                                               logic replay);
        robPkg::CommitOp op;
        logic intCode;
        intCode = !(e.isFP && e.flags.fp.isExc);
        op.valid = 1'b1;
        op.sqN = sqN;
        op.tag = e.tag;
        // Faulting ops write nothing, send them to x0
        op.name = (intCode && e.flags.code inside {robPkg::ILLEGAL, robPkg::LD_FAULT,
                   robPkg::ST_FAULT}) ? '0 : e.name;
        op.isBranch = intCode && (e.flags.code == robPkg::BRANCH
                                  || e.flags.code == robPkg::PRED_TAKEN);
        op.replay = replay;
        return op;
    endfunction

    assign commitMode = !branch.taken && !replayPlan.active;
    assign readIndex = replayPlan.active ? robPkg::RobIdx'(replayIter) : robPkg::RobIdx'(head);
    assign retireClear = commitMode ? commitPlan.retire : '0;
    assign stopped = stop;
    assign trapEntry = window[commitPlan.trapSlot];
    assign curSqN = head;
    assign maxSqN = head + robPkg::SqN'(`ROB_LENGTH - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            stop <= 1'b0;
            fpFlags <= '0;
            mispredFlush <= 1'b0;
            curFetchId <= '1;
            trap.valid <= 1'b0;
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                commit[k].valid <= 1'b0;
            end
        end else begin
            stop <= 1'b0;
            fpFlags <= '0;
            trap.valid <= 1'b0;
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                commit[k].valid <= 1'b0;
            end

            if (branch.taken) begin
                mispredFlush <= 1'b0;
                curFetchId <= branch.fetchId;
            end else if (replayPlan.active) begin
                // Replay rolls back the rename map, the head stays put
                mispredFlush <= 1'b1;
                for (int k = 0; k < `ROB_WIDTH; k++) begin
                    if (replayPlan.replay[k]) begin
                        commit[k] <= makeOp(window[k], replayIter + robPkg::SqN'(k), 1'b1);
                    end
                end
            end else begin
                mispredFlush <= 1'b0;
                for (int k = 0; k < `ROB_WIDTH; k++) begin
                    if (commitPlan.retire[k]) begin
                        commit[k] <= makeOp(window[k], head + robPkg::SqN'(k), 1'b0);
                        curFetchId <= window[k].fetchId;
                    end
                end
                if (commitPlan.trapValid) begin
                    trap.valid <= 1'b1;
                    trap.sqN <= head + robPkg::SqN'(commitPlan.trapSlot);
                    trap.flags <= trapEntry.flags.code;
                    trap.tag <= trapEntry.tag;
                    trap.fetchId <= trapEntry.fetchId;
                    stop <= trapEntry.flags.code >= robPkg::FENCE;
                end
                fpFlags <= commitPlan.fpFlags;
                head <= head + robPkg::SqN'(commitPlan.count);
            end
        end
    end

endmodule

//--- robPkg.sv
`include "rob_defines.svh"

package robPkg;

    typedef logic [`ROB_SQN_W-1:0] SqN;
    typedef logic [$clog2(`ROB_LENGTH)-1:0] RobIdx;
    typedef logic [$clog2(`ROB_WIDTH)-1:0] SlotIdx;
    typedef logic [5:0] Tag;
    typedef logic [4:0] RegName;
    typedef logic [2:0] FetchId;

    // PRED_TAKEN and above go to the trap port, FENCE and above also stop retirement
    typedef enum logic [3:0] {
        NONE       = 4'd0,
        BRANCH     = 4'd1,
        PRED_TAKEN = 4'd2,
        FENCE      = 4'd3,
        TRAP       = 4'd4,
        ILLEGAL    = 4'd5,
        LD_FAULT   = 4'd6,
        ST_FAULT   = 4'd7,
        NX         = 4'd15
    } FlagCode;

    // Bit positions in the FP exception flag vector
    localparam logic [2:0] FP_NX = 3'd0;
    localparam logic [2:0] FP_UF = 3'd1;
    localparam logic [2:0] FP_OF = 3'd2;
    localparam logic [2:0] FP_DZ = 3'd3;
    localparam logic [2:0] FP_NV = 3'd4;

    typedef struct packed {
        logic       isExc;
        logic [2:0] idx;
    } FpExc;

    // Integer ops carry a FlagCode, FP ops that finish normally carry an FpExc
    typedef union packed {
        FlagCode code;
        FpExc    fp;
    } RobFlags;

    typedef struct packed {
        logic    valid;
        logic    wrap;
        Tag      tag;
        RegName  name;
        FetchId  fetchId;
        logic    isFP;
        RobFlags flags;
    } RobEntry;

    typedef struct packed {
        logic   valid;
        SqN     sqN;
        Tag     tag;
        RegName name;
        FetchId fetchId;
        logic   isFP;
        logic   trapAtDecode;
    } RenameOp;

    typedef struct packed {
        logic    valid;
        SqN      sqN;
        RobFlags flags;
    } WbOp;

    typedef struct packed {
        logic   taken;
        SqN     sqN;
        FetchId fetchId;
    } BranchIn;

    typedef struct packed {
        logic   valid;
        SqN     sqN;
        RegName name;
        Tag     tag;
        logic   isBranch;
        logic   replay;
    } CommitOp;

    typedef struct packed {
        logic    valid;
        SqN      sqN;
        FlagCode flags;
        Tag      tag;
        FetchId  fetchId;
    } TrapOp;

    typedef struct packed {
        logic [$clog2(`ROB_WIDTH+1)-1:0] count;
        logic [`ROB_WIDTH-1:0]           retire;
        logic                            trapValid;
        SlotIdx                          trapSlot;
        logic [4:0]                      fpFlags;
    } CommitPlan;

    typedef struct packed {
        logic [`ROB_WIDTH-1:0] replay;
        logic                  active;
        logic                  done;
    } ReplayPlan;

    // True when a is strictly younger than b, tolerant of sequence wrap
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

//--- robStorage.sv
`timescale 1ns/10ps
`include "rob_defines.svh"

module robStorage (
    input  logic              clk,
    input  logic              rst,
    input  robPkg::RenameOp   enq [`ROB_WIDTH-1:0],
    input  robPkg::WbOp       wb [`ROB_WB-1:0],
    input  robPkg::BranchIn   branch,
    input  robPkg::RobIdx     readIndex,
    input  logic [`ROB_WIDTH-1:0] retireClear,
    output robPkg::RobEntry   window [`ROB_WIDTH-1:0]
);

    robPkg::RobEntry entries [`ROB_LENGTH-1:0];

    logic [`ROB_WIDTH-1:0] enqClash;
    logic [`ROB_WB-1:0] wbNotDone;

    // Window of consecutive entries, wrapping at the end of the array
    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            window[k] = entries[readIndex + robPkg::RobIdx'(k)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_LENGTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (retireClear[k]) begin
                    entries[readIndex + robPkg::RobIdx'(k)].valid <= 1'b0;
                end
            end

            if (branch.taken) begin
                // Drop everything on the wrong path
                for (int i = 0; i < `ROB_LENGTH; i++) begin
                    if (robPkg::isYounger({entries[i].wrap, robPkg::RobIdx'(i)}, branch.sqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end else begin
                for (int k = 0; k < `ROB_WIDTH; k++) begin
                    if (enq[k].valid) begin
                        entries[robPkg::RobIdx'(enq[k].sqN)].valid <= 1'b1;
                        entries[robPkg::RobIdx'(enq[k].sqN)].wrap <= enq[k].sqN[`ROB_SQN_W-1];
                        entries[robPkg::RobIdx'(enq[k].sqN)].tag <= enq[k].tag;
                        entries[robPkg::RobIdx'(enq[k].sqN)].name <= enq[k].name;
                        entries[robPkg::RobIdx'(enq[k].sqN)].fetchId <= enq[k].fetchId;
                        entries[robPkg::RobIdx'(enq[k].sqN)].isFP <= enq[k].isFP;
                        entries[robPkg::RobIdx'(enq[k].sqN)].flags.code <=
                            enq[k].trapAtDecode ? robPkg::TRAP : robPkg::NX;
                    end
                end
            end

            // Completion, ignoring results from the wrong path
            for (int k = 0; k < `ROB_WB; k++) begin
                if (wb[k].valid && !(branch.taken && robPkg::isYounger(wb[k].sqN, branch.sqN))) begin
                    entries[robPkg::RobIdx'(wb[k].sqN)].flags <= wb[k].flags;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            enqClash[k] = enq[k].valid && !branch.taken
                && entries[robPkg::RobIdx'(enq[k].sqN)].valid;
        end
        for (int k = 0; k < `ROB_WB; k++) begin
            wbNotDone[k] = wb[k].valid && wb[k].flags.code == robPkg::NX;
        end
    end

    // Enqueue must stay inside the window that maxSqN reports
    assert property (@(posedge clk) disable iff (rst) enqClash == '0);

    assert property (@(posedge clk) disable iff (rst) wbNotDone == '0);

endmodule

//--- robTop.sv
`timescale 1ns/10ps
`include "rob_defines.svh"

module robTop (
    input  logic            clk,
    input  logic            rst,
    input  robPkg::RenameOp enq [`ROB_WIDTH-1:0],
    input  robPkg::WbOp     wb [`ROB_WB-1:0],
    input  robPkg::BranchIn branch,
    output robPkg::CommitOp commit [`ROB_WIDTH-1:0],
    output robPkg::TrapOp   trap,
    output logic [4:0]      fpFlags,
    output logic            mispredFlush,
    output robPkg::SqN      curSqN,
    output robPkg::SqN      maxSqN,
    output robPkg::FetchId  curFetchId
);

    robPkg::RobEntry window [`ROB_WIDTH-1:0];
    robPkg::RobIdx readIndex;
    logic [`ROB_WIDTH-1:0] retireClear;
    logic stopped;
    robPkg::CommitPlan commitPlan;
    robPkg::ReplayPlan replayPlan;
    robPkg::SqN replayIter;

    robStorage i_storage (
        .clk         (clk),
        .rst         (rst),
        .enq         (enq),
        .wb          (wb),
        .branch      (branch),
        .readIndex   (readIndex),
        .retireClear (retireClear),
        .window      (window)
    );

    // Scan and walker look at the same window, the controller picks one
    commitScan i_scan (
        .window  (window),
        .head    (curSqN),
        .stopped (stopped),
        .plan    (commitPlan)
    );

    replayWalker i_walker (
        .clk    (clk),
        .rst    (rst),
        .branch (branch),
        .head   (curSqN),
        .window (window),
        .iter   (replayIter),
        .plan   (replayPlan)
    );

    retireControl i_retire (
        .clk          (clk),
        .rst          (rst),
        .commitPlan   (commitPlan),
        .replayPlan   (replayPlan),
        .replayIter   (replayIter),
        .window       (window),
        .branch       (branch),
        .readIndex    (readIndex),
        .retireClear  (retireClear),
        .stopped      (stopped),
        .commit       (commit),
        .trap         (trap),
        .fpFlags      (fpFlags),
        .mispredFlush (mispredFlush),
        .curSqN       (curSqN),
        .maxSqN       (maxSqN),
        .curFetchId   (curFetchId)
    );

endmodule

//--- rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// Number of buffer entries
`define ROB_LENGTH 16

// Ops accepted and retired per cycle
`define ROB_WIDTH 2

// Writeback ports
`define ROB_WB 2

// Index bits plus one wrap bit
`define ROB_SQN_W 5

`endif

//--- tbRob.sv
`timescale 1ns/10ps
`include "rob_defines.svh"

module tbRob;

    localparam int NUM_ROWS = 24;

    // One row per op
    // Rows up to endBatch are enqueued as one group
    typedef struct packed {
        logic       endBatch;
        logic [5:0] tag;
        logic [4:0] name;
        logic       isFP;
        logic       decTrap;
        logic [3:0] wbFlags;
        logic       mispred;
        logic [4:0] expName;
        logic [4:0] expFp;
        logic       expTrap;
    } OpRow;

    typedef struct packed {
        robPkg::SqN sqN;
        logic [5:0] tag;
        logic [4:0] name;
        logic       replay;
        logic       isBranch;
        logic [2:0] fetchId;
        logic [4:0] fp;
        logic       trap;
        logic [3:0] trapCode;
    } ExpCommit;

    logic clk;
    logic rst;
    robPkg::RenameOp enq [`ROB_WIDTH-1:0];
    robPkg::WbOp wb [`ROB_WB-1:0];
    robPkg::BranchIn branch;
    robPkg::CommitOp commit [`ROB_WIDTH-1:0];
    robPkg::TrapOp trap;
    logic [4:0] fpFlags;
    logic mispredFlush;
    robPkg::SqN curSqN;
    robPkg::SqN maxSqN;
    robPkg::FetchId curFetchId;

    OpRow rows [NUM_ROWS];
    ExpCommit expQ [$];
    robPkg::SqN nextSqN;
    integer seed;
    int errorCount;
    int checkCount;

    robTop i_dut (
        .clk          (clk),
        .rst          (rst),
        .enq          (enq),
        .wb           (wb),
        .branch       (branch),
        .commit       (commit),
        .trap         (trap),
        .fpFlags      (fpFlags),
        .mispredFlush (mispredFlush),
        .curSqN       (curSqN),
        .maxSqN       (maxSqN),
        .curFetchId   (curFetchId)
    );

    always #4 clk = ~clk;

    task automatic checkValue(string sigName, logic [31:0] actual, logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, sigName, actual, expected);
        end
    endtask

    // Column order is endBatch, tag, name, isFP, decTrap, wbFlags, mispred, expName, expFp, expTrap
    task automatic loadTable();
        rows[0]  = '{1'b0, 6'd1, 5'd1, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd1, 5'b0, 1'b0};
        rows[1]  = '{1'b0, 6'd2, 5'd2, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd2, 5'b0, 1'b0};
        rows[2]  = '{1'b0, 6'd3, 5'd3, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd3, 5'b0, 1'b0};
        rows[3]  = '{1'b0, 6'd4, 5'd4, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd4, 5'b0, 1'b0};
        rows[4]  = '{1'b0, 6'd5, 5'd5, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd5, 5'b0, 1'b0};
        rows[5]  = '{1'b1, 6'd6, 5'd6, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd6, 5'b0, 1'b0};
        // Faulting ops write x0 and trap
        rows[6]  = '{1'b0, 6'd7, 5'd7, 1'b0, 1'b0, robPkg::ILLEGAL, 1'b0, 5'd0, 5'b0, 1'b1};
        rows[7]  = '{1'b0, 6'd8, 5'd8, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd8, 5'b0, 1'b0};
        rows[8]  = '{1'b0, 6'd9, 5'd9, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd9, 5'b0, 1'b0};
        rows[9]  = '{1'b1, 6'd10, 5'd10, 1'b0, 1'b1, robPkg::NONE, 1'b0, 5'd10, 5'b0, 1'b1};
        // FP codes put the marker bit over the index so UF is 9 and DZ is 11
        rows[10] = '{1'b0, 6'd11, 5'd11, 1'b1, 1'b0, 4'b1001, 1'b0, 5'd11, 5'b00011, 1'b0};
        rows[11] = '{1'b0, 6'd12, 5'd12, 1'b1, 1'b0, 4'b1011, 1'b0, 5'd12, 5'b01000, 1'b0};
        rows[12] = '{1'b0, 6'd13, 5'd13, 1'b1, 1'b0, robPkg::NONE, 1'b0, 5'd13, 5'b0, 1'b0};
        rows[13] = '{1'b1, 6'd14, 5'd14, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd14, 5'b0, 1'b0};
        // Mispredicted branch in the middle squashes the last three ops
        rows[14] = '{1'b0, 6'd15, 5'd15, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd15, 5'b0, 1'b0};
        rows[15] = '{1'b0, 6'd16, 5'd16, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd16, 5'b0, 1'b0};
        rows[16] = '{1'b0, 6'd17, 5'd17, 1'b0, 1'b0, robPkg::BRANCH, 1'b1, 5'd17, 5'b0, 1'b0};
        rows[17] = '{1'b0, 6'd18, 5'd18, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd18, 5'b0, 1'b0};
        rows[18] = '{1'b0, 6'd19, 5'd19, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd19, 5'b0, 1'b0};
        rows[19] = '{1'b1, 6'd20, 5'd20, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd20, 5'b0, 1'b0};
        // Reuses the squashed sequence numbers
        rows[20] = '{1'b0, 6'd21, 5'd21, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd21, 5'b0, 1'b0};
        rows[21] = '{1'b0, 6'd22, 5'd22, 1'b0, 1'b0, robPkg::ST_FAULT, 1'b0, 5'd0, 5'b0, 1'b1};
        rows[22] = '{1'b0, 6'd23, 5'd23, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd23, 5'b0, 1'b0};
        rows[23] = '{1'b1, 6'd24, 5'd24, 1'b0, 1'b0, robPkg::NONE, 1'b0, 5'd24, 5'b0, 1'b0};
    endtask

    task automatic enqueueOp(int slot, int r, robPkg::SqN sqN);
        enq[slot].valid = 1'b1;
        enq[slot].sqN = sqN;
        enq[slot].tag = rows[r].tag;
        enq[slot].name = rows[r].name;
        enq[slot].fetchId = rows[r].tag[2:0];
        enq[slot].isFP = rows[r].isFP;
        enq[slot].trapAtDecode = rows[r].decTrap;
    endtask

    task automatic expectCommit(int r, robPkg::SqN sqN, logic replay);
        ExpCommit e;
        e.sqN = sqN;
        e.tag = rows[r].tag;
        e.name = replay ? rows[r].name : rows[r].expName;
        e.replay = replay;
        // Replay runs before the outcome of the op is known
        e.isBranch = !replay && !rows[r].decTrap
            && (rows[r].wbFlags == robPkg::BRANCH || rows[r].wbFlags == robPkg::PRED_TAKEN);
        e.fetchId = rows[r].tag[2:0];
        e.fp = rows[r].expFp;
        e.trap = rows[r].expTrap && !replay;
        e.trapCode = rows[r].decTrap ? 4'(robPkg::TRAP) : rows[r].wbFlags;
        expQ.push_back(e);
    endtask

    task automatic runBatch(int first, int last);
        int cnt;
        int keep;
        int brIdx;
        int tmp;
        int j;
        int order [$];
        robPkg::SqN base;
        cnt = last - first + 1;
        base = nextSqN;
        brIdx = -1;
        for (int i = cnt - 1; i >= 0; i--) begin
            if (rows[first + i].mispred) begin
                brIdx = i;
            end
        end
        keep = (brIdx < 0) ? cnt : brIdx + 1;

        // Replay of head through the branch precedes normal in-order retirement
        if (brIdx >= 0) begin
            for (int i = 0; i < keep; i++) begin
                expectCommit(first + i, base + robPkg::SqN'(i), 1'b1);
            end
        end
        for (int i = 0; i < keep; i++) begin
            expectCommit(first + i, base + robPkg::SqN'(i), 1'b0);
        end
        nextSqN = base + robPkg::SqN'(keep);

        for (int i = 0; i < cnt; i += 2) begin
            @(negedge clk);
            enqueueOp(0, first + i, base + robPkg::SqN'(i));
            enq[1].valid = 1'b0;
            if (i + 1 < cnt) begin
                enqueueOp(1, first + i + 1, base + robPkg::SqN'(i + 1));
            end
        end
        @(negedge clk);
        enq[0].valid = 1'b0;
        enq[1].valid = 1'b0;

        if (brIdx >= 0) begin
            branch.taken = 1'b1;
            branch.sqN = base + robPkg::SqN'(brIdx);
            branch.fetchId = rows[first + brIdx].tag[2:0];
            @(negedge clk);
            branch.taken = 1'b0;
            while (!mispredFlush) @(negedge clk);
            // Fetch restarts behind the branch
            checkValue("curFetchId", curFetchId, rows[first + brIdx].tag[2:0]);
            while (mispredFlush) @(negedge clk);
        end

        // Ops flagged at decode are already complete
        for (int i = 0; i < keep; i++) begin
            if (!rows[first + i].decTrap) begin
                order.push_back(i);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        while (order.size() > 0) begin
            @(negedge clk);
            for (int k = 0; k < `ROB_WB; k++) begin
                wb[k].valid = 1'b0;
                if (order.size() > 0) begin
                    j = order.pop_front();
                    wb[k].valid = 1'b1;
                    wb[k].sqN = base + robPkg::SqN'(j);
                    wb[k].flags = rows[first + j].wbFlags;
                end
            end
        end
        @(negedge clk);
        wb[0].valid = 1'b0;
        wb[1].valid = 1'b0;
        while (expQ.size() != 0) @(negedge clk);
    endtask

    // Every retired or replayed op is matched against the model queue
    always @(negedge clk) begin
        ExpCommit e;
        ExpCommit trapItem;
        logic [4:0] fpExp;
        logic trapExp;
        logic retired;
        logic [2:0] fetchExp;
        if (!rst) begin
            fpExp = '0;
            trapExp = 1'b0;
            trapItem = '0;
            retired = 1'b0;
            fetchExp = '0;
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (commit[k].valid && expQ.size() == 0) begin
                    errorCount++;
                    $display("commit of sequence number %0d at %0t ns was not expected",
                             commit[k].sqN, $time);
                end else if (commit[k].valid) begin
                    e = expQ.pop_front();
                    checkValue("commit.sqN", commit[k].sqN, e.sqN);
                    checkValue("commit.tag", commit[k].tag, e.tag);
                    checkValue("commit.name", commit[k].name, e.name);
                    checkValue("commit.replay", commit[k].replay, e.replay);
                    checkValue("commit.isBranch", commit[k].isBranch, e.isBranch);
                    checkValue("mispredFlush", mispredFlush, e.replay);
                    if (!e.replay) begin
                        fpExp = fpExp | e.fp;
                        retired = 1'b1;
                        fetchExp = e.fetchId;
                    end
                    if (e.trap) begin
                        trapExp = 1'b1;
                        trapItem = e;
                    end
                end
            end
            checkValue("fpFlags", fpFlags, fpExp);
            // Fetch ID follows the youngest op retired this cycle
            if (retired) begin
                checkValue("curFetchId", curFetchId, fetchExp);
            end
            checkValue("trap.valid", trap.valid, trapExp);
            if (trap.valid && trapExp) begin
                checkValue("trap.sqN", trap.sqN, trapItem.sqN);
                checkValue("trap.flags", trap.flags, trapItem.trapCode);
                checkValue("trap.tag", trap.tag, trapItem.tag);
                checkValue("trap.fetchId", trap.fetchId, trapItem.fetchId);
            end
        end
    end

    initial begin
        int first;
        clk = 1'b0;
        rst = 1'b1;
        seed = 32'hcc651b08;
        errorCount = 0;
        checkCount = 0;
        nextSqN = '0;
        branch = '0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            enq[k] = '0;
        end
        for (int k = 0; k < `ROB_WB; k++) begin
            wb[k] = '0;
        end
        loadTable();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checkValue("commit[0].valid", commit[0].valid, 1'b0);
        checkValue("commit[1].valid", commit[1].valid, 1'b0);
        checkValue("trap.valid", trap.valid, 1'b0);
        checkValue("mispredFlush", mispredFlush, 1'b0);
        checkValue("fpFlags", fpFlags, 5'b0);
        checkValue("curSqN", curSqN, 0);
        checkValue("maxSqN", maxSqN, `ROB_LENGTH - 1);
        checkValue("curFetchId", curFetchId, 3'b111);

        first = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].endBatch) begin
                runBatch(first, r);
                first = r + 1;
            end
        end
        repeat (10) @(negedge clk);
        checkValue("curSqN", curSqN, nextSqN);
        checkValue("maxSqN", maxSqN, robPkg::SqN'(nextSqN + `ROB_LENGTH - 1));

        $display("%0d checks run, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Generous bound of twenty cycles per table row
    initial begin
        repeat (NUM_ROWS * 20) @(posedge clk);
        $display("timeout: the DUT did not retire all ops of the table in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
